//--- dv/rfPipeTb.sv
`default_nettype none

`include "rfPipe_params.svh"

module rfPipeTb import opPkg::*, regPkg::*; ();

    localparam int driveDelay = 10;
    localparam int directedCount = 40;
    localparam int randCount = 200;
    // worst case per instruction is a full MUL plus a random gap
    localparam int limitCycles = (directedCount + randCount) * (`MUL_CYCLES + 4) + 20;

    logic     clk;
    logic     rst;
    logic     instValid;
    logic     instReady;
    opT       instOp;
    regAddrT  instDest;
    regAddrT  instSrc1;
    regAddrT  instSrc2;
    byteMaskT instMask;
    logic     retireValid;
    regAddrT  retireDest;
    byteMaskT retireMask;
    regWordT  retireData;

    logic [31:0] lfsr;
    int          errCount = 0;
    // seed words ride on the source 1 read data, the ISA has no immediates
    logic        injectOn;
    regWordT     injectVal;

    // architectural state in program order, updated at acceptance
    regWordT     model [`RF_DEPTH];
    regAddrT     expDestQ[$];
    byteMaskT    expMaskQ[$];
    regWordT     expDataQ[$];
    int          pending = 0;
    regAddrT     headDest;
    byteMaskT    headMask;
    regWordT     headData;

    rfPipeTop UUT (
        .clk(clk), .rst(rst),
        .instValid(instValid), .instReady(instReady), .instOp(instOp),
        .instDest(instDest), .instSrc1(instSrc1), .instSrc2(instSrc2), .instMask(instMask),
        .retireValid(retireValid), .retireDest(retireDest),
        .retireMask(retireMask), .retireData(retireData)
    );

    always #50 clk = ~clk;

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic regWordT laneBits(input byteMaskT mask);
        regWordT bits;
        for (int b = 0; b < `RF_BYTES; b++) begin
            bits[b*8 +: 8] = {8{mask[b]}};
        end
        return bits;
    endfunction

    function automatic regWordT calcResult(input opT op, input regWordT a, input regWordT b);
        case (op)
            OP_ADD:  return a + b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_PASS: return a;
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    function automatic regWordT readModel(input regAddrT addr);
        return (addr == '0) ? '0 : model[addr];
    endfunction

    // retire bookkeeping first, then the newly accepted instruction
    always @(posedge clk) begin
        regWordT a;
        regWordT res;
        if (!rst) begin
            if (retireValid && (expDestQ.size() > 0)) begin
                void'(expDestQ.pop_front());
                void'(expMaskQ.pop_front());
                void'(expDataQ.pop_front());
            end
            if (instValid && instReady) begin
                a = injectOn ? injectVal : readModel(instSrc1);
                res = calcResult(instOp, a, readModel(instSrc2));
                // r0 stays zero whatever the mask
                if (instDest != '0) begin
                    model[instDest] = (model[instDest] & ~laneBits(instMask))
                                    | (res & laneBits(instMask));
                end
                expDestQ.push_back(instDest);
                expMaskQ.push_back(instMask);
                expDataQ.push_back(res);
            end
            pending <= expDestQ.size();
            if (expDestQ.size() > 0) begin
                headDest <= expDestQ[0];
                headMask <= expMaskQ[0];
                headData <= expDataQ[0];
            end
        end
    end

    // every retire needs an outstanding acceptance
    retireKnown: assert property (@(posedge clk) disable iff (rst) retireValid |-> pending != 0)
        else begin
            errCount++;
            $display("unexpected retire at %0t with no instruction outstanding", $time);
        end

    // in-order compare with the oldest expected write, enabled bytes only
    retireMatch: assert property (@(posedge clk) disable iff (rst)
            retireValid && (pending != 0)
            |-> (retireDest == headDest) && (retireMask == headMask)
                && (((retireData ^ headData) & laneBits(headMask)) == '0))
        else begin
            errCount++;
            $display("MISMATCH at %0t: retire r%0d mask %b data %h, expected r%0d mask %b data %h",
                $time, $sampled(retireDest), $sampled(retireMask), $sampled(retireData),
                $sampled(headDest), $sampled(headMask), $sampled(headData));
        end

    // holds the instruction until the edge where it is taken
    task automatic sendInst(input opT op, input regAddrT dest, input regAddrT src1,
                            input regAddrT src2, input byteMaskT mask);
        logic taken;
        instOp = op;
        instDest = dest;
        instSrc1 = src1;
        instSrc2 = src2;
        instMask = mask;
        instValid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = instReady;
            @(posedge clk);
        end
        #driveDelay;
        instValid = 1'b0;
    endtask

    task automatic idle(input int n);
        instValid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #driveDelay;
        end
    endtask

    task automatic loadSeed(input regAddrT dest, input regWordT value);
        injectVal = value;
        injectOn = 1'b1;
        force UUT.rData1 = injectVal;
        sendInst(OP_PASS, dest, '0, '0, 4'hF);
        release UUT.rData1;
        injectOn = 1'b0;
    endtask

    initial begin
        #(limitCycles * 100);
        $display("timeout: pipeline stopped issuing or retiring, %0d retire errors", errCount);
        $display("Regression failed");
        $finish;
    end

    initial begin
        opT       op;
        regAddrT  dest;
        regAddrT  src1;
        regAddrT  src2;
        byteMaskT mask;
        clk = 1'b0;
        rst = 1'b1;
        instValid = 1'b0;
        instOp = OP_ADD;
        instDest = '0;
        instSrc1 = '0;
        instSrc2 = '0;
        instMask = '0;
        injectOn = 1'b0;
        injectVal = '0;
        lfsr = 32'ha314;
        for (int i = 0; i < `RF_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        #driveDelay;
        rst = 1'b0;
        // seed r1..r7, then spread them with an ADD chain
        for (int r = 1; r < 8; r++) begin
            loadSeed(regAddrT'(r), randBits(32));
        end
        for (int r = 8; r < 12; r++) begin
            sendInst(OP_ADD, regAddrT'(r), regAddrT'(r - 1), regAddrT'(r - 7), 4'hF);
        end
        // two overlapping partial writers, reader d instructions behind the second
        for (int d = 1; d <= 3; d++) begin
            sendInst(OP_ADD, 5'd16, 5'd1, 5'd2, 4'b0011);
            sendInst(OP_XOR, 5'd16, 5'd3, 5'd4, 4'b0110);
            for (int f = 1; f < d; f++) begin
                sendInst(OP_OR, 5'd20, 5'd5, 5'd6, 4'hF);
            end
            sendInst(OP_PASS, regAddrT'(16 + d), 5'd16, 5'd0, 4'hF);
        end
        // r0 write is dropped, later reads still see zero
        sendInst(OP_PASS, 5'd0, 5'd1, 5'd0, 4'hF);
        sendInst(OP_ADD, 5'd21, 5'd0, 5'd2, 4'hF);
        idle(3);
        sendInst(OP_OR, 5'd22, 5'd0, 5'd0, 4'hF);
        // lone MUL, then MULs with dependents at distance 1 and 2
        sendInst(OP_MUL, 5'd24, 5'd1, 5'd2, 4'hF);
        idle(6);
        sendInst(OP_MUL, 5'd25, 5'd3, 5'd4, 4'hF);
        sendInst(OP_ADD, 5'd26, 5'd25, 5'd1, 4'hF);
        sendInst(OP_MUL, 5'd27, 5'd26, 5'd25, 4'b1001);
        sendInst(OP_OR, 5'd28, 5'd2, 5'd3, 4'hF);
        sendInst(OP_XOR, 5'd29, 5'd5, 5'd27, 4'hF);
        sendInst(OP_MUL, 5'd30, 5'd1, 5'd1, 4'hF);
        sendInst(OP_MUL, 5'd31, 5'd30, 5'd2, 4'hF);
        // small register window keeps dependencies frequent
        for (int i = 0; i < randCount; i++) begin
            if (randBits(2) == '0) begin
                idle(1 + randBits(1));
            end
            op = opT'(randBits(3) % 5);
            dest = regAddrT'(randBits(3));
            src1 = regAddrT'(randBits(3));
            src2 = regAddrT'(randBits(3));
            mask = byteMaskT'(randBits(4));
            sendInst(op, dest, src1, src2, mask);
        end
        wait (pending == 0);
        repeat (4) @(posedge clk);
        $display("closing: %0d retire errors, %0d protocol errors",
            errCount, UUT.svaChk.errCount);
        if ((errCount == 0) && (UUT.svaChk.errCount == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/rfPipeTb_sva.sv
`default_nettype none

`include "rfPipe_params.svh"

module rfPipeTb_sva import opPkg::*, regPkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     instValid,
    input logic     instReady,
    input opT       instOp,
    input regAddrT  instDest,
    input regAddrT  instSrc1,
    input regAddrT  instSrc2,
    input byteMaskT instMask,
    input logic     retireValid,
    input regAddrT  retireDest,
    // internal stage state of the DUT
    input logic     exIsMul,
    input logic     exValid,
    input logic     memValid
);

    // failure count, read by the testbench for the closing line
    int errCount = 0;

    logic accept;

    assign accept = instValid && instReady;

    // whole pipe empty and not ready while reset is applied
    resetQuiet: assert property (@(posedge clk)
            rst |-> !instReady && !retireValid && !exValid && !memValid)
        else begin
            $error("pipeline not idle while reset is asserted");
            errCount++;
        end

    // empty pipe has no hazards, so ready comes up right away
    readyAfterReset: assert property (@(posedge clk) $fell(rst) |=> instReady)
        else begin
            $error("instReady did not rise in the first cycle after reset");
            errCount++;
        end

    // a waiting instruction stays put until it is taken
    heldStable: assert property (@(posedge clk) disable iff (rst)
            instValid && !instReady |=> instValid && $stable(instOp) && $stable(instDest)
                && $stable(instSrc1) && $stable(instSrc2) && $stable(instMask))
        else begin
            $error("instruction dropped or changed while waiting for instReady");
            errCount++;
        end

    // no MUL ahead in EX, so nothing can hold this one back
    aluLatency: assert property (@(posedge clk) disable iff (rst)
            accept && (instOp != OP_MUL) && !exIsMul
            |-> ##3 retireValid && (retireDest == $past(instDest, 3)))
        else begin
            $error("ALU instruction did not retire three cycles after acceptance");
            errCount++;
        end

    // MUL sits in MEM for the full count before it reaches WB
    mulLatency: assert property (@(posedge clk) disable iff (rst)
            accept && (instOp == OP_MUL) && !exIsMul
            |-> ##(`MUL_CYCLES + 2) retireValid
                && (retireDest == $past(instDest, `MUL_CYCLES + 2)))
        else begin
            $error("MUL did not retire at its fixed latency");
            errCount++;
        end

    // reader of a MUL that is still in EX has to wait
    mulReaderStall: assert property (@(posedge clk) disable iff (rst)
            accept && (instOp == OP_MUL) && (instMask != '0) && (instDest != '0)
            ##1 instValid
                && ((instSrc1 == $past(instDest)) || (instSrc2 == $past(instDest)))
            |-> !instReady)
        else begin
            $error("instruction reading a MUL result was accepted while the MUL was in EX");
            errCount++;
        end

    // issue frozen while the MUL counts in MEM
    mulIssueHold: assert property (@(posedge clk) disable iff (rst)
            accept && (instOp == OP_MUL) && !exIsMul
            |-> ##2 !instReady [*(`MUL_CYCLES - 1)])
        else begin
            $error("instReady was high while a MUL was still counting in MEM");
            errCount++;
        end

endmodule

bind rfPipeTop rfPipeTb_sva svaChk (
    .clk(clk), .rst(rst),
    .instValid(instValid), .instReady(instReady), .instOp(instOp),
    .instDest(instDest), .instSrc1(instSrc1), .instSrc2(instSrc2), .instMask(instMask),
    .retireValid(retireValid), .retireDest(retireDest),
    .exIsMul(exIsMul), .exValid(exValid), .memValid(memValid)
);

`default_nettype wire

//--- logic/execUnit.sv
`default_nettype none

module execUnit import opPkg::*, regPkg::*; (
    input  opT      op,
    input  regWordT opA,
    input  regWordT opB,
    output regWordT result
);

    regWordT sum;
    regWordT product;

    assign sum = opA + opB;

    // only the low word is kept, MEM registers it on entry
    assign product = opA * opB;

    always_comb begin
        case (op)
            OP_ADD: begin
                result = sum;
            end
            OP_OR: begin
                result = opA | opB;
            end
            OP_XOR: begin
                result = opA ^ opB;
            end
            OP_PASS: begin
                // source 1 straight through
                result = opA;
            end
            OP_MUL: begin
                result = product;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/issueCtrl.sv
`default_nettype none

module issueCtrl import opPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic instValid,
    output logic instReady,
    input  logic hazardEx,
    input  logic hazardMem,
    // a valid MUL is the next thing to enter MEM
    input  logic memIsMul,
    input  logic mulDone,
    output logic mulStart,
    output logic exHold,
    output logic exBubble,
    output logic memHold,
    output logic wbBubble
);

    ctlStateT state;
    ctlStateT nextState;

    // low until the first edge after reset release
    logic started;
    logic advance;

    // pipe moves when running, or in the cycle the MUL finishes
    assign advance = (state == ST_RUN) || mulDone;

    assign instReady = started && advance && !hazardEx && !hazardMem;

    // frozen front end while the MUL counts
    assign exHold  = !advance;
    assign memHold = !advance;
    assign wbBubble = !advance;

    // EX loads an empty slot whenever nothing is accepted
    assign exBubble = advance && !(instValid && instReady);

    // timer starts as the MUL moves from EX into MEM
    assign mulStart = advance && memIsMul;

    always_comb begin
        nextState = state;
        if (mulStart) begin
            nextState = ST_MULWAIT;
        end else if (mulDone) begin
            nextState = ST_RUN;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_RUN;
            started <= 1'b0;
        end else begin
            state   <= nextState;
            started <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/mulTimer.sv
`default_nettype none

`include "rfPipe_params.svh"

module mulTimer (
    input  logic clk,
    input  logic rst,
    input  logic mulStart,
    output logic mulDone
);

    localparam int cntW = $clog2(`MUL_CYCLES + 1);

    logic [cntW-1:0] count;
    logic            busy;

    // start reloads even in the done cycle, for back-to-back MULs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (mulStart) begin
            busy  <= 1'b1;
            count <= cntW'(`MUL_CYCLES - 1);
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // last MEM cycle of the MUL
    assign mulDone = busy && (count == '0);

endmodule

`default_nettype wire

//--- logic/opPkg.sv
`default_nettype none

package opPkg;

    // operations understood by the exec unit
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_OR   = 3'd1,
        OP_XOR  = 3'd2,
        // copies source 1
        OP_PASS = 3'd3,
        // multi-cycle, low word of the product
        OP_MUL  = 3'd4
    } opT;

    // issue controller states
    typedef enum logic {
        ST_RUN     = 1'b0,
        // MUL sits in MEM, front of the pipe frozen
        ST_MULWAIT = 1'b1
    } ctlStateT;

endpackage

`default_nettype wire

//--- logic/pipeStage.sv
`default_nettype none

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    input  payloadT inData,
    input  logic    hold,
    input  logic    bubble,
    output logic    outValid,
    output payloadT outData
);

    // hold keeps the current entry, bubble loads an empty slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= bubble ? 1'b0 : inValid;
        end
    end

    // payload only meaningful with outValid
    always_ff @(posedge clk) begin
        if (!hold && !bubble) begin
            outData <= inData;
        end
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`default_nettype none

`include "rfPipe_params.svh"

module regFile import regPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     re1,
    input  regAddrT  rAddr1,
    output regWordT  rData1,
    input  logic     re2,
    input  regAddrT  rAddr2,
    output regWordT  rData2,
    // writeback port, driven from WB
    input  byteMaskT we,
    input  regAddrT  wAddr,
    input  regWordT  wData,
    // younger writers for forwarding
    input  byteMaskT exMask,
    input  regAddrT  exDest,
    input  regWordT  exData,
    input  logic     exIsMul,
    input  byteMaskT memMask,
    input  regAddrT  memDest,
    input  regWordT  memData,
    input  logic     memMulPending,
    output logic     hazardEx,
    output logic     hazardMem
);

    localparam int byteW = `RF_DATA_W / `RF_BYTES;

    regWordT regs [`RF_DEPTH];

    logic srcValid1;
    logic srcValid2;

    // byte-masked writeback, r0 is never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int b = 0; b < `RF_BYTES; b++) begin
                if (we[b] && (wAddr != '0)) begin
                    regs[wAddr][b*byteW +: byteW] <= wData[b*byteW +: byteW];
                end
            end
        end
    end

    // per byte, youngest matching writer wins: EX, then MEM, then WB, then array
    function automatic regWordT fwdRead(input logic re, input regAddrT addr);
        regWordT  word;
        byteMaskT exHit;
        byteMaskT memHit;
        byteMaskT wbHit;
        exHit  = exMask  & {`RF_BYTES{addr == exDest}};
        memHit = memMask & {`RF_BYTES{addr == memDest}};
        wbHit  = we      & {`RF_BYTES{addr == wAddr}};
        for (int b = 0; b < `RF_BYTES; b++) begin
            if (!re || (addr == '0)) begin
                word[b*byteW +: byteW] = '0;
            end else if (exHit[b]) begin
                word[b*byteW +: byteW] = exData[b*byteW +: byteW];
            end else if (memHit[b]) begin
                word[b*byteW +: byteW] = memData[b*byteW +: byteW];
            end else if (wbHit[b]) begin
                word[b*byteW +: byteW] = wData[b*byteW +: byteW];
            end else begin
                word[b*byteW +: byteW] = regs[addr][b*byteW +: byteW];
            end
        end
        return word;
    endfunction

    always_comb begin
        rData1 = fwdRead(re1, rAddr1);
        rData2 = fwdRead(re2, rAddr2);
    end

    // r0 and disabled ports never cause a stall
    assign srcValid1 = re1 && (rAddr1 != '0);
    assign srcValid2 = re2 && (rAddr2 != '0);

    // MUL in EX has no usable result yet
    assign hazardEx = exIsMul && (exMask != '0) &&
                      ((srcValid1 && (rAddr1 == exDest)) ||
                       (srcValid2 && (rAddr2 == exDest)));

    // MUL in MEM still counting
    assign hazardMem = memMulPending &&
                       ((srcValid1 && (rAddr1 == memDest)) ||
                        (srcValid2 && (rAddr2 == memDest)));

endmodule

`default_nettype wire

//--- logic/regPkg.sv
`default_nettype none

`include "rfPipe_params.svh"

package regPkg;

    import opPkg::*;

    typedef logic [`RF_ADDR_W-1:0] regAddrT;
    typedef logic [`RF_DATA_W-1:0] regWordT;
    // one bit per byte lane, all zero means no write
    typedef logic [`RF_BYTES-1:0]  byteMaskT;

    // control fields that ride along every stage
    typedef struct packed {
        opT       op;
        regAddrT  dest;
        byteMaskT mask;
    } stageCtlT;

    // EX holds the operands read at issue
    typedef struct packed {
        stageCtlT ctl;
        regWordT  opA;
        regWordT  opB;
    } exPayloadT;

    // MEM adds the registered result, a MUL product lands here on entry
    typedef struct packed {
        stageCtlT ctl;
        regWordT  opA;
        regWordT  opB;
        regWordT  result;
    } memPayloadT;

    // WB only needs what gets written back
    typedef struct packed {
        stageCtlT ctl;
        regWordT  result;
    } wbPayloadT;

endpackage

`default_nettype wire

//--- logic/rfPipeTop.sv
`default_nettype none

module rfPipeTop import opPkg::*, regPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     instValid,
    output logic     instReady,
    input  opT       instOp,
    input  regAddrT  instDest,
    input  regAddrT  instSrc1,
    input  regAddrT  instSrc2,
    input  byteMaskT instMask,
    output logic     retireValid,
    output regAddrT  retireDest,
    output byteMaskT retireMask,
    output regWordT  retireData
);

    regWordT    rData1;
    regWordT    rData2;
    regWordT    exResult;
    logic       hazardEx;
    logic       hazardMem;
    logic       mulStart;
    logic       mulDone;
    logic       exHold;
    logic       exBubble;
    logic       memHold;
    logic       wbBubble;

    exPayloadT  exIn;
    exPayloadT  exOut;
    logic       exValid;
    memPayloadT memIn;
    memPayloadT memOut;
    logic       memValid;
    wbPayloadT  wbIn;
    wbPayloadT  wbOut;
    logic       wbValid;

    // stage masks only count while the stage is valid
    byteMaskT   exMaskV;
    byteMaskT   memMaskV;
    byteMaskT   wbMaskV;
    logic       exIsMul;
    logic       memMulPending;

    assign exMaskV  = exValid  ? exOut.ctl.mask  : '0;
    assign memMaskV = memValid ? memOut.ctl.mask : '0;
    assign wbMaskV  = wbValid  ? wbOut.ctl.mask  : '0;

    // EX MUL is also the one about to enter MEM
    assign exIsMul       = exValid && (exOut.ctl.op == OP_MUL);
    assign memMulPending = memValid && (memOut.ctl.op == OP_MUL) && !mulDone;

    // operands are read in the issue cycle
    assign exIn = '{ctl: '{op: instOp, dest: instDest, mask: instMask},
                    opA: rData1, opB: rData2};
    assign memIn = '{ctl: exOut.ctl, opA: exOut.opA, opB: exOut.opB, result: exResult};
    assign wbIn  = '{ctl: memOut.ctl, result: memOut.result};

    regFile rf (
        .clk(clk), .rst(rst),
        .re1(instValid), .rAddr1(instSrc1), .rData1(rData1),
        .re2(instValid), .rAddr2(instSrc2), .rData2(rData2),
        .we(wbMaskV), .wAddr(wbOut.ctl.dest), .wData(wbOut.result),
        .exMask(exMaskV), .exDest(exOut.ctl.dest), .exData(exResult), .exIsMul(exIsMul),
        .memMask(memMaskV), .memDest(memOut.ctl.dest), .memData(memOut.result),
        .memMulPending(memMulPending),
        .hazardEx(hazardEx), .hazardMem(hazardMem)
    );

    issueCtrl ctrl (
        .clk(clk), .rst(rst),
        .instValid(instValid), .instReady(instReady),
        .hazardEx(hazardEx), .hazardMem(hazardMem),
        .memIsMul(exIsMul), .mulDone(mulDone), .mulStart(mulStart),
        .exHold(exHold), .exBubble(exBubble), .memHold(memHold), .wbBubble(wbBubble)
    );

    mulTimer timer (.clk(clk), .rst(rst), .mulStart(mulStart), .mulDone(mulDone));

    execUnit alu (.op(exOut.ctl.op), .opA(exOut.opA), .opB(exOut.opB), .result(exResult));

    pipeStage #(.payloadT(exPayloadT)) exStage (
        .clk(clk), .rst(rst), .inValid(instValid), .inData(exIn),
        .hold(exHold), .bubble(exBubble), .outValid(exValid), .outData(exOut)
    );

    // MEM never inserts its own bubbles
    pipeStage #(.payloadT(memPayloadT)) memStage (
        .clk(clk), .rst(rst), .inValid(exValid), .inData(memIn),
        .hold(memHold), .bubble(1'b0), .outValid(memValid), .outData(memOut)
    );

    // WB never stalls, writeback cannot wait
    pipeStage #(.payloadT(wbPayloadT)) wbStage (
        .clk(clk), .rst(rst), .inValid(memValid), .inData(wbIn),
        .hold(1'b0), .bubble(wbBubble), .outValid(wbValid), .outData(wbOut)
    );

    assign retireValid = wbValid;
    assign retireDest  = wbOut.ctl.dest;
    assign retireMask  = wbOut.ctl.mask;
    assign retireData  = wbOut.result;

endmodule

`default_nettype wire

//--- logic/rfPipe_params.svh
`ifndef RF_PIPE_PARAMS_SVH
`define RF_PIPE_PARAMS_SVH

// data word width in bits
`define RF_DATA_W 32

// register index width
`define RF_ADDR_W 5

// byte lanes per word, one write enable each
`define RF_BYTES 4

// number of architectural registers, r0 reads as zero
`define RF_DEPTH 32

// cycles a MUL occupies the MEM stage
`define MUL_CYCLES 3

`endif

//--- rfPipeTop.f
+incdir+logic
logic/opPkg.sv
logic/regPkg.sv
logic/regFile.sv
logic/issueCtrl.sv
logic/mulTimer.sv
logic/execUnit.sv
logic/pipeStage.sv
logic/rfPipeTop.sv
dv/rfPipeTb_sva.sv
dv/rfPipeTb.sv
